// ==== Bender.yml ====
package:
  name: pci_arbiter

sources:
  - source/pci_debug_pkg.sv
  - source/debug_read_seq.sv
  - source/axi_event_log.sv
  - source/pci_response_steer.sv
  - source/pci_arbiter_top.sv
  - target: test
    files:
      - verif/pci_arbiter_props.sv
      - verif/tb_pci_arbiter.sv

// ==== project.f ====
source/pci_debug_pkg.sv
source/debug_read_seq.sv
source/axi_event_log.sv
source/pci_response_steer.sv
source/pci_arbiter_top.sv
verif/pci_arbiter_props.sv
verif/tb_pci_arbiter.sv

// ==== source/axi_event_log.sv ====
`timescale 1ns/1ps

module axi_event_log #(
   parameter int log_depth_log2 = 4
) (
   input  logic                               clk,
   input  logic                               rstn,
   input  logic                               mem_arvalid,
   input  logic                               mem_arready,
   input  logic [pci_debug_pkg::id_w-1:0]     mem_arid,
   input  logic [pci_debug_pkg::addr_w-1:0]   mem_araddr,
   input  logic                               mem_rvalid,
   input  logic                               mem_rready,
   input  logic [pci_debug_pkg::id_w-1:0]     mem_rid,
   input  logic [pci_debug_pkg::data_w-1:0]   mem_rdata,
   input  logic                               mem_rlast,
   input  logic                               start,
   input  logic [pci_debug_pkg::len_w-1:0]    arlen,
   input  logic                               rready,
   output logic                               rvalid,
   output logic [pci_debug_pkg::data_w-1:0]   rdata,
   output logic                               rlast,
   output logic [15:0]                        log_size
);
   import pci_debug_pkg::*;

   localparam int depth = 1 << log_depth_log2;

   log_entry_t                log_mem [depth];
   log_entry_t                entry;
   logic [log_depth_log2:0]   wr_ptr;
   logic [log_depth_log2:0]   rd_ptr;
   logic [log_depth_log2:0]   count;
   logic                      ar_fire;
   logic                      r_fire;
   logic                      full;
   logic                      empty;
   logic                      push;
   logic                      pop;
   logic                      active;
   logic [len_w-1:0]          beats_left;

   assign ar_fire = mem_arvalid & mem_arready;
   assign r_fire  = mem_rvalid & mem_rready;

   // Extra pointer bit tells full from empty.
   assign count = wr_ptr - rd_ptr;
   assign full  = (count == (log_depth_log2 + 1)'(depth));
   assign empty = (count == '0);

   assign push = (ar_fire | r_fire) & ~full;   // Drop when full.
   assign pop  = rvalid & rready & ~empty;

   always_comb begin
      entry         = '0;
      entry.ar_fire = ar_fire;
      entry.r_fire  = r_fire;
      entry.arid    = mem_arid;
      entry.araddr  = mem_araddr[log_addr_w-1:0];
      entry.rid     = mem_rid;
      entry.rdata   = mem_rdata[log_data_w-1:0];
      entry.rlast   = mem_rlast;
   end

   always_ff @(posedge clk) begin
      if (push) log_mem[wr_ptr[log_depth_log2-1:0]] <= entry;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // Playback burst, one beat per cycle while the host accepts.
   always_ff @(posedge clk) begin
      if (!rstn) begin
         active     <= 1'b0;
         beats_left <= '0;
      end else if (start) begin
         active     <= 1'b1;
         beats_left <= arlen;
      end else if (rvalid && rready) begin
         if (rlast) begin
            active <= 1'b0;
         end else begin
            beats_left <= beats_left - 1'b1;
         end
      end
   end

   assign rvalid   = active;
   assign rlast    = active && (beats_left == '0);
   assign log_size = 16'(count);

   always_comb begin
      if (empty) begin
         rdata = '0;   // Beats past the log read as zero.
      end else begin
         rdata = data_w'(log_mem[rd_ptr[log_depth_log2-1:0]]);
      end
   end

endmodule

// ==== source/debug_read_seq.sv ====
`timescale 1ns/1ps

module debug_read_seq #(
   parameter int n_tiles = 4
) (
   input  logic                                 clk,
   input  logic                                 rstn,
   input  logic                                 pci_arvalid,
   input  logic                                 pci_arready,
   input  logic [pci_debug_pkg::addr_w-1:0]     pci_araddr,
   input  logic [pci_debug_pkg::id_w-1:0]       pci_arid,
   input  logic                                 pci_rvalid,
   input  logic                                 pci_rready,
   input  logic                                 pci_rlast,
   output logic                                 busy,
   output logic [pci_debug_pkg::field_w-1:0]    tile_sel,
   output logic [pci_debug_pkg::field_w-1:0]    comp,
   output logic [pci_debug_pkg::id_w-1:0]       rid_hold,
   output logic [n_tiles-1:0]                   tile_arvalid,
   output logic                                 log_start
);
   import pci_debug_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_received,
      st_waiting
   } state_t;

   state_t state;
   logic   accept;
   logic   last_beat;
   logic   to_log;

   assign accept    = pci_arvalid & pci_arready & pci_araddr[debug_addr_bit];
   assign last_beat = pci_rvalid & pci_rready & pci_rlast;
   assign busy      = (state != st_idle);
   assign to_log    = (tile_sel >= field_w'(n_tiles));   // Ids past the last tile hit the log.

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: begin
               if (accept) state <= st_received;
            end
            st_received: state <= st_waiting;
            st_waiting: begin
               if (last_beat) state <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   // Request fields, held for the whole read.
   always_ff @(posedge clk) begin
      if (state == st_idle && accept) begin
         tile_sel <= pci_araddr[tile_lsb +: field_w];
         comp     <= pci_araddr[comp_lsb +: field_w];
         rid_hold <= pci_arid;
      end
   end

   always_comb begin
      for (int i = 0; i < n_tiles; i++) begin
         tile_arvalid[i] = (state == st_received) && (tile_sel == field_w'(i));
      end
      log_start = (state == st_received) && to_log;
   end

endmodule

// ==== source/pci_arbiter_top.sv ====
`timescale 1ns/1ps

module pci_arbiter_top #(
   parameter int n_tiles        = 4,
   parameter int log_depth_log2 = 4
) (
   input  logic                                             clk,
   input  logic                                             rstn,
   input  logic                                             pci_arvalid,
   input  logic [pci_debug_pkg::id_w-1:0]                   pci_arid,
   input  logic [pci_debug_pkg::addr_w-1:0]                 pci_araddr,
   input  logic [pci_debug_pkg::len_w-1:0]                  pci_arlen,
   input  logic                                             pci_rready,
   output logic                                             pci_arready,
   output logic                                             pci_rvalid,
   output logic [pci_debug_pkg::id_w-1:0]                   pci_rid,
   output logic [pci_debug_pkg::data_w-1:0]                 pci_rdata,
   output logic                                             pci_rlast,
   output logic                                             mem_arvalid,
   output logic [pci_debug_pkg::id_w-1:0]                   mem_arid,
   output logic [pci_debug_pkg::addr_w-1:0]                 mem_araddr,
   output logic [pci_debug_pkg::len_w-1:0]                  mem_arlen,
   output logic                                             mem_rready,
   input  logic                                             mem_arready,
   input  logic                                             mem_rvalid,
   input  logic [pci_debug_pkg::id_w-1:0]                   mem_rid,
   input  logic [pci_debug_pkg::data_w-1:0]                 mem_rdata,
   input  logic                                             mem_rlast,
   output logic [n_tiles-1:0]                               tile_arvalid,
   output logic [pci_debug_pkg::len_w-1:0]                  tile_arlen,
   output logic [pci_debug_pkg::field_w-1:0]                tile_comp,
   output logic                                             tile_rready,
   input  logic [n_tiles-1:0]                               tile_rvalid,
   input  logic [n_tiles-1:0]                               tile_rlast,
   input  logic [n_tiles-1:0][pci_debug_pkg::data_w-1:0]    tile_rdata,
   output logic [15:0]                                      log_size
);
   import pci_debug_pkg::*;

   logic               busy;
   logic [field_w-1:0] tile_sel;
   logic [id_w-1:0]    rid_hold;
   logic               log_start;
   logic [len_w-1:0]   arlen_q;
   logic               log_rvalid;
   logic [data_w-1:0]  log_rdata;
   logic               log_rlast;

   assign mem_arid   = pci_arid;
   assign mem_araddr = pci_araddr;
   assign mem_arlen  = pci_arlen;

   // Burst length for the debug target, valid with the request pulse.
   always_ff @(posedge clk) begin
      if (pci_arvalid && pci_arready) arlen_q <= pci_arlen;
   end

   assign tile_arlen  = arlen_q;
   assign tile_rready = busy & pci_rready;

   debug_read_seq #(.n_tiles(n_tiles)) u_seq (
      .clk(clk), .rstn(rstn),
      .pci_arvalid(pci_arvalid), .pci_arready(pci_arready),
      .pci_araddr(pci_araddr), .pci_arid(pci_arid),
      .pci_rvalid(pci_rvalid), .pci_rready(pci_rready), .pci_rlast(pci_rlast),
      .busy(busy), .tile_sel(tile_sel), .comp(tile_comp), .rid_hold(rid_hold),
      .tile_arvalid(tile_arvalid), .log_start(log_start)
   );

   axi_event_log #(.log_depth_log2(log_depth_log2)) u_log (
      .clk(clk), .rstn(rstn),
      .mem_arvalid(mem_arvalid), .mem_arready(mem_arready),
      .mem_arid(mem_arid), .mem_araddr(mem_araddr),
      .mem_rvalid(mem_rvalid), .mem_rready(mem_rready),
      .mem_rid(mem_rid), .mem_rdata(mem_rdata), .mem_rlast(mem_rlast),
      .start(log_start), .arlen(arlen_q), .rready(pci_rready),
      .rvalid(log_rvalid), .rdata(log_rdata), .rlast(log_rlast),
      .log_size(log_size)
   );

   pci_response_steer #(.n_tiles(n_tiles)) u_steer (
      .busy(busy), .tile_sel(tile_sel), .rid_hold(rid_hold),
      .pci_arvalid(pci_arvalid), .pci_araddr(pci_araddr), .pci_rready(pci_rready),
      .mem_arready(mem_arready), .mem_rvalid(mem_rvalid), .mem_rid(mem_rid),
      .mem_rdata(mem_rdata), .mem_rlast(mem_rlast),
      .tile_rvalid(tile_rvalid), .tile_rlast(tile_rlast), .tile_rdata(tile_rdata),
      .log_rvalid(log_rvalid), .log_rdata(log_rdata), .log_rlast(log_rlast),
      .pci_arready(pci_arready), .pci_rvalid(pci_rvalid), .pci_rid(pci_rid),
      .pci_rdata(pci_rdata), .pci_rlast(pci_rlast),
      .mem_arvalid(mem_arvalid), .mem_rready(mem_rready)
   );

endmodule

// ==== source/pci_debug_pkg.sv ====
package pci_debug_pkg;

   // Host port widths.
   localparam int addr_w = 40;
   localparam int id_w   = 16;
   localparam int data_w = 64;
   localparam int len_w  = 8;   // Beats per burst is len + 1.

   // Debug address decode.
   localparam int debug_addr_bit = 36;
   localparam int tile_lsb       = 28;
   localparam int comp_lsb       = 20;
   localparam int field_w        = 8;   // Width of tile and component fields.

   // Only the low part of the address and data goes into a log record.
   localparam int log_addr_w = 32;
   localparam int log_data_w = 32;

   // One event recorded on the memory port.
   typedef struct packed {
      logic                  ar_fire;
      logic                  r_fire;
      logic [id_w-1:0]       arid;
      logic [log_addr_w-1:0] araddr;
      logic [id_w-1:0]       rid;
      logic [log_data_w-1:0] rdata;
      logic                  rlast;
   } log_entry_t;

endpackage

// ==== source/pci_response_steer.sv ====
`timescale 1ns/1ps

module pci_response_steer #(
   parameter int n_tiles = 4
) (
   input  logic                                             busy,
   input  logic [pci_debug_pkg::field_w-1:0]                tile_sel,
   input  logic [pci_debug_pkg::id_w-1:0]                   rid_hold,
   input  logic                                             pci_arvalid,
   input  logic [pci_debug_pkg::addr_w-1:0]                 pci_araddr,
   input  logic                                             pci_rready,
   input  logic                                             mem_arready,
   input  logic                                             mem_rvalid,
   input  logic [pci_debug_pkg::id_w-1:0]                   mem_rid,
   input  logic [pci_debug_pkg::data_w-1:0]                 mem_rdata,
   input  logic                                             mem_rlast,
   input  logic [n_tiles-1:0]                               tile_rvalid,
   input  logic [n_tiles-1:0]                               tile_rlast,
   input  logic [n_tiles-1:0][pci_debug_pkg::data_w-1:0]    tile_rdata,
   input  logic                                             log_rvalid,
   input  logic [pci_debug_pkg::data_w-1:0]                 log_rdata,
   input  logic                                             log_rlast,
   output logic                                             pci_arready,
   output logic                                             pci_rvalid,
   output logic [pci_debug_pkg::id_w-1:0]                   pci_rid,
   output logic [pci_debug_pkg::data_w-1:0]                 pci_rdata,
   output logic                                             pci_rlast,
   output logic                                             mem_arvalid,
   output logic                                             mem_rready
);
   import pci_debug_pkg::*;

   logic              is_debug;
   logic              src_rvalid;
   logic              src_rlast;
   logic [data_w-1:0] src_rdata;

   assign is_debug = pci_araddr[debug_addr_bit];

   // Debug source, log unless the id names a tile.
   always_comb begin
      src_rvalid = log_rvalid;
      src_rlast  = log_rlast;
      src_rdata  = log_rdata;
      for (int i = 0; i < n_tiles; i++) begin
         if (tile_sel == field_w'(i)) begin
            src_rvalid = tile_rvalid[i];
            src_rlast  = tile_rlast[i];
            src_rdata  = tile_rdata[i];
         end
      end
   end

   always_comb begin
      if (busy) begin
         pci_arready = 1'b0;
         mem_arvalid = 1'b0;
         mem_rready  = 1'b0;
         pci_rvalid  = src_rvalid;
         pci_rid     = rid_hold;
         pci_rdata   = src_rdata;
         pci_rlast   = src_rlast;
      end else begin
         // Debug addresses never reach memory.
         pci_arready = is_debug ? 1'b1 : mem_arready;
         mem_arvalid = pci_arvalid & ~is_debug;
         mem_rready  = pci_rready;
         pci_rvalid  = mem_rvalid;
         pci_rid     = mem_rid;
         pci_rdata   = mem_rdata;
         pci_rlast   = mem_rlast;
      end
   end

endmodule

// ==== verif/pci_arbiter_props.sv ====
`timescale 1ns/1ps

module pci_arbiter_props #(
   parameter int n_tiles = 4
) (
   input logic               clk,
   input logic               rstn,
   input logic               busy,
   input logic               mem_arvalid,
   input logic               mem_rready,
   input logic [n_tiles-1:0] tile_arvalid
);

   // Memory port stays shut for the whole debug read.
   property mem_gated_p;
      @(posedge clk) disable iff (!rstn)
         busy |-> (!mem_arvalid && !mem_rready);
   endproperty

   property one_request_p;
      @(posedge clk) disable iff (!rstn)
         $onehot0(tile_arvalid);
   endproperty

   // Single-cycle request pulse.
   property short_pulse_p;
      @(posedge clk) disable iff (!rstn)
         (|tile_arvalid) |=> (tile_arvalid == '0);
   endproperty

   mem_gated_a: assert property (mem_gated_p)
      else $error("memory port active while a debug read is busy");
   one_request_a: assert property (one_request_p)
      else $error("more than one tile request bit high");
   short_pulse_a: assert property (short_pulse_p)
      else $error("tile request held longer than one cycle");

endmodule

bind pci_arbiter_top pci_arbiter_props #(.n_tiles(n_tiles)) u_props (
   .clk(clk),
   .rstn(rstn),
   .busy(busy),
   .mem_arvalid(mem_arvalid),
   .mem_rready(mem_rready),
   .tile_arvalid(tile_arvalid)
);

// ==== verif/tb_pci_arbiter.sv ====
`timescale 1ns/1ps

module tb_pci_arbiter;
   import pci_debug_pkg::*;

   localparam int n_tiles   = 4;
   localparam int log_depth = 16;
   localparam int timeout   = 200;   // Cycles allowed for any single wait.
   localparam int n_tests   = 14;

   typedef enum int {rd_mem, rd_tile, rd_log} kind_t;

   typedef struct {
      kind_t kind;
      int    tile;
      int    len;
      int    comp;
      int    id;
      int    beats;
      bit    stall;
   } row_t;

   logic                             clk = 1'b0;
   logic                             rstn;
   logic                             pci_arvalid;
   logic [id_w-1:0]                  pci_arid;
   logic [addr_w-1:0]                pci_araddr;
   logic [len_w-1:0]                 pci_arlen;
   logic                             pci_rready;
   logic                             pci_arready;
   logic                             pci_rvalid;
   logic [id_w-1:0]                  pci_rid;
   logic [data_w-1:0]                pci_rdata;
   logic                             pci_rlast;
   logic                             mem_arvalid;
   logic [id_w-1:0]                  mem_arid;
   logic [addr_w-1:0]                mem_araddr;
   logic [len_w-1:0]                 mem_arlen;
   logic                             mem_rready;
   logic                             mem_arready;
   logic                             mem_rvalid = 1'b0;
   logic [id_w-1:0]                  mem_rid = '0;
   logic [data_w-1:0]                mem_rdata = '0;
   logic                             mem_rlast = 1'b0;
   logic [n_tiles-1:0]               tile_arvalid;
   logic [len_w-1:0]                 tile_arlen;
   logic [7:0]                       tile_comp;
   logic                             tile_rready;
   logic [n_tiles-1:0]               tile_rvalid = '0;
   logic [n_tiles-1:0]               tile_rlast = '0;
   logic [n_tiles-1:0][data_w-1:0]   tile_rdata = '0;
   logic [15:0]                      log_size;

   row_t              rows [n_tests];
   logic [98:0]       log_q [$];   // Reference copy of the event log.
   logic [63:0]       mem_expect [$];
   logic [31:0]       mem_rnd = 32'd30930;
   logic [31:0]       stall_rnd = 32'd30930;
   logic [len_w-1:0]  mem_left;
   logic              ar_ev;
   logic              r_ev;
   int                tile_beat [n_tiles];
   int                tile_len [n_tiles];
   int                pulses [n_tiles];
   int                mem_av_cnt;
   logic [7:0]        comp_seen;
   int                cur_test;
   int                test_errors;
   int                n_pass;
   int                n_fail;
   bit                timed_out;

   pci_arbiter_top #(.n_tiles(n_tiles), .log_depth_log2(4)) dut (.*);

   always #10 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [addr_w-1:0] row_addr(input int i);
      logic [addr_w-1:0] a;
      a = 40'h0_5A00_0000 | (40'(rows[i].id) << 8);
      if (rows[i].kind != rd_mem) begin
         a                   = '0;
         a[debug_addr_bit]   = 1'b1;
         a[tile_lsb +: 8]    = rows[i].tile[7:0];
         a[comp_lsb +: 8]    = rows[i].comp[7:0];
         a[11:0]             = 12'h3c0;
      end
      return a;
   endfunction

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp)
      else begin
         $display("Error at %0t: test %0d %s is %h, expected %h",
                  $time, cur_test, what, got, exp);
         test_errors++;
      end
   endtask

   task automatic memory_beat();
      logic [63:0] d;
      mem_rnd = lcg_next(mem_rnd);
      d[63:32] = mem_rnd;
      mem_rnd = lcg_next(mem_rnd);
      d[31:0] = mem_rnd;
      mem_rvalid <= 1'b1;
      mem_rdata  <= d;
      mem_rlast  <= (mem_left == '0);
      mem_expect.push_back(d);
      if (mem_left != '0) mem_left = mem_left - 1'b1;
   endtask

   // Memory slave, one burst at a time.
   always @(posedge clk) begin
      if (!rstn) begin
         mem_rvalid <= 1'b0;
      end else if (mem_arvalid && mem_arready) begin
         mem_left = mem_arlen;
         mem_rid <= mem_arid;
         memory_beat();
      end else if (mem_rvalid && mem_rready) begin
         if (mem_rlast) mem_rvalid <= 1'b0;
         else memory_beat();
      end
   end

   // Tile k answers with k * 256 + beat.
   always @(posedge clk) begin
      if (!rstn) begin
         tile_rvalid <= '0;
      end else begin
         for (int k = 0; k < n_tiles; k++) begin
            if (tile_arvalid[k]) begin
               tile_beat[k]   = 0;
               tile_len[k]    = int'(tile_arlen);
               comp_seen      = tile_comp;
               tile_rvalid[k] <= 1'b1;
            end else if (tile_rvalid[k] && tile_rready) begin
               tile_beat[k]   = tile_beat[k] + 1;
               tile_rvalid[k] <= !tile_rlast[k];
            end
            tile_rdata[k] <= 64'(k * 256 + tile_beat[k]);
            tile_rlast[k] <= (tile_beat[k] == tile_len[k]);
         end
      end
   end

   // Memory-port events as seen from the host side, capped at the log depth.
   always @(posedge clk) begin
      if (rstn) begin
         ar_ev = pci_arvalid && !pci_araddr[debug_addr_bit] && mem_arready;
         r_ev  = mem_rvalid && pci_rready;
         if ((ar_ev || r_ev) && log_q.size() < log_depth) begin
            log_q.push_back({ar_ev, r_ev, pci_arid, pci_araddr[31:0],
                             mem_rid, mem_rdata[31:0], mem_rlast});
         end
      end
   end

   always @(posedge clk) begin
      if (rstn) begin
         for (int k = 0; k < n_tiles; k++) begin
            if (tile_arvalid[k]) pulses[k]++;
         end
         if (mem_arvalid) mem_av_cnt++;
         assert (!(dut.busy && (mem_arvalid || mem_rready)))
         else begin
            $display("Error at %0t: memory port not gated during a debug read", $time);
            test_errors++;
         end
      end
   end

   task automatic run_row(input int i);
      int          n;
      int          k;
      int          beats;
      bit          done;
      logic [63:0] exp;
      logic [98:0] ent;
      cur_test    = i;
      test_errors = 0;
      @(posedge clk);
      for (k = 0; k < n_tiles; k++) pulses[k] = 0;
      mem_av_cnt  = 0;
      pci_arvalid <= 1'b1;
      pci_arid    <= 16'(rows[i].id);
      pci_araddr  <= row_addr(i);
      pci_arlen   <= 8'(rows[i].len);
      pci_rready  <= 1'b1;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!pci_arready && n < timeout);
      if (!pci_arready) begin
         $display("Timeout: the address of test %0d was never accepted", i);
         timed_out = 1'b1;
         return;
      end
      if (rows[i].kind == rd_mem) begin
         check_value("mem_araddr", 64'(mem_araddr), 64'(row_addr(i)));
         check_value("mem_arlen", 64'(mem_arlen), 64'(rows[i].len));
      end
      pci_arvalid <= 1'b0;
      n     = 0;
      beats = 0;
      done  = 1'b0;
      while (!done && n < timeout) begin
         stall_rnd = lcg_next(stall_rnd);
         pci_rready <= rows[i].stall ? stall_rnd[27] : 1'b1;
         @(posedge clk);
         n++;
         if (pci_rvalid && pci_rready) begin
            if (rows[i].kind == rd_tile) begin
               exp = 64'(rows[i].tile * 256 + beats);
            end else if (rows[i].kind == rd_mem) begin
               exp = (mem_expect.size() > 0) ? mem_expect.pop_front() : 'x;
            end else if (log_q.size() > 0) begin
               ent = log_q.pop_front();
               exp = ent[63:0];   // Only the low data_w bits of an entry fit a beat.
            end else begin
               exp = '0;
            end
            check_value("rdata", pci_rdata, exp);
            check_value("rid", 64'(pci_rid), 64'(rows[i].id));
            beats++;
            done = pci_rlast;
         end
      end
      if (!done) begin
         $display("Timeout: test %0d never returned its last beat", i);
         timed_out = 1'b1;
         return;
      end
      pci_rready <= 1'b1;
      @(posedge clk);
      check_value("beat count", 64'(beats), 64'(rows[i].beats));
      check_value("rvalid after rlast", 64'(pci_rvalid), 64'(0));
      check_value("log_size", 64'(log_size), 64'(log_q.size()));
      check_value("mem_arvalid cycles", 64'(mem_av_cnt), 64'(rows[i].kind == rd_mem));
      for (k = 0; k < n_tiles; k++) begin
         check_value("tile_arvalid pulses", 64'(pulses[k]),
                     64'(rows[i].kind == rd_tile && rows[i].tile == k));
      end
      if (rows[i].kind == rd_tile) check_value("tile_comp", 64'(comp_seen), 64'(rows[i].comp));
      $display("Test %0d %s tile %0d len %0d: %0d beats, %0d errors",
               i, rows[i].kind.name(), rows[i].tile, rows[i].len, beats, test_errors);
      if (test_errors == 0) n_pass++;
      else n_fail++;
   endtask

   initial begin
      rstn        = 1'b0;
      pci_arvalid = 1'b0;
      pci_arid    = '0;
      pci_araddr  = '0;
      pci_arlen   = '0;
      pci_rready  = 1'b0;
      mem_arready = 1'b1;
      timed_out   = 1'b0;
      n_pass      = 0;
      n_fail      = 0;
      // kind, tile, len, comp, id, beats, stall
      rows[0]  = '{rd_mem,  0,   3,  0, 16'h0011, 4,  1'b0};
      rows[1]  = '{rd_tile, 0,   2,  3, 16'h0021, 3,  1'b0};
      rows[2]  = '{rd_tile, 2,   0,  1, 16'h0022, 1,  1'b0};
      rows[3]  = '{rd_log,  4,   3,  0, 16'h0031, 4,  1'b0};
      rows[4]  = '{rd_mem,  0,   1,  0, 16'h0012, 2,  1'b1};
      rows[5]  = '{rd_tile, 3,   5,  9, 16'h0023, 6,  1'b1};
      rows[6]  = '{rd_log,  255, 7,  0, 16'h0032, 8,  1'b0};   // Runs past the log.
      rows[7]  = '{rd_mem,  0,   7,  0, 16'h0013, 8,  1'b0};
      rows[8]  = '{rd_mem,  0,   4,  0, 16'h0014, 5,  1'b1};
      rows[9]  = '{rd_mem,  0,   2,  0, 16'h0015, 3,  1'b0};   // Log overflows here.
      rows[10] = '{rd_tile, 1,   3,  7, 16'h0024, 4,  1'b1};
      rows[11] = '{rd_log,  5,   15, 0, 16'h0033, 16, 1'b1};
      rows[12] = '{rd_mem,  0,   5,  0, 16'h0016, 6,  1'b1};
      rows[13] = '{rd_log,  4,   2,  0, 16'h0034, 3,  1'b1};
      repeat (3) @(posedge clk);
      rstn <= 1'b1;
      for (int i = 0; i < n_tests; i++) begin
         run_row(i);
         if (timed_out) break;
      end
      $display("Tests passed: %0d, failed: %0d, of %0d", n_pass, n_fail, n_tests);
      if (n_fail == 0 && !timed_out) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule
